//--- Bender.yml
package:
  name: ddr_stat_bridge

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ddr_stat_pkg.sv
      - hdl/stat_req_router.sv
      - hdl/stat_lane.sv
      - hdl/stat_resp_merger.sv
      - hdl/ddr_stat_bridge.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/ddr_stat_responder.sv
      - test/tb_ddr_stat_bridge.sv

//--- hdl/ddr_stat_bridge.sv
`include "ddr_stat_consts.svh"
`timescale 1ns/1ns
`default_nettype none

module ddr_stat_bridge
(
   input  wire                      clk_main_a0,
   input  wire                      pipe_rst_n,
   // host side
   input  wire ddr_stat_pkg::stat_req_t  host_req,
   input  wire ddr_stat_pkg::stat_chan_t host_chan,
   output ddr_stat_pkg::host_rsp_t  host_rsp,
   // one status port per channel
   output ddr_stat_pkg::stat_req_t  ddr_req [`STAT_NUM_CHAN],
   input  wire ddr_stat_pkg::stat_rsp_t  ddr_rsp [`STAT_NUM_CHAN]
);

   import ddr_stat_pkg::*;

   stat_req_t  lane_req [`STAT_NUM_CHAN];
   stat_rsp_t  lane_rsp [`STAT_NUM_CHAN];

   // ------------------------------
   // request routing
   // ------------------------------
   // merged ack retires the outstanding flag of its channel
   stat_req_router i_stat_req_router
   (
      .clk_main_a0 (clk_main_a0),
      .pipe_rst_n  (pipe_rst_n),
      .host_req    (host_req),
      .host_chan   (host_chan),
      .done_ack    (host_rsp.rsp.ack),
      .done_chan   (host_rsp.chan),
      .lane_req    (lane_req)
   );

   // ------------------------------
   // channel lanes
   // ------------------------------
   // absent channels answer locally
   for (genvar g = 0; g < `STAT_NUM_CHAN; g++)
   begin : g_lane
      stat_lane
      #(
         .PRESENT (int'((`STAT_PRESENT_MASK >> g) & 1))
      )
      i_stat_lane
      (
         .clk_main_a0 (clk_main_a0),
         .pipe_rst_n  (pipe_rst_n),
         .lane_req    (lane_req[g]),
         .ddr_req     (ddr_req[g]),
         .ddr_rsp     (ddr_rsp[g]),
         .lane_rsp    (lane_rsp[g])
      );
   end

   // replies back to the host, tagged
   stat_resp_merger i_stat_resp_merger
   (
      .clk_main_a0 (clk_main_a0),
      .pipe_rst_n  (pipe_rst_n),
      .lane_rsp    (lane_rsp),
      .host_rsp    (host_rsp)
   );

endmodule

`default_nettype wire

//--- hdl/ddr_stat_consts.svh
`default_nettype none

`ifndef DDR_STAT_CONSTS_SVH
`define DDR_STAT_CONSTS_SVH

// ------------------------------
// lane pipeline
// ------------------------------
// register stages per direction, request and reply alike
`define STAT_PIPE_STAGES  8

// ------------------------------
// channels
// ------------------------------
`define STAT_NUM_CHAN     3
// bit i set means channel i has a real status port behind it
`define STAT_PRESENT_MASK 3'b001

// ------------------------------
// field widths
// ------------------------------
`define STAT_ADDR_W       8
`define STAT_DATA_W       32
// interrupt vector returned with every reply
`define STAT_INT_W        8

`endif

`default_nettype wire

//--- hdl/ddr_stat_pkg.sv
`include "ddr_stat_consts.svh"
`default_nettype none

package ddr_stat_pkg;

   // ------------------------------
   // encodings
   // ------------------------------
   // request opcode, nop means no strobe this cycle
   typedef enum logic [1:0]
   {
      STAT_NOP = 2'd0,
      STAT_WR  = 2'd1,
      STAT_RD  = 2'd2
   } stat_op_e;

   // reset release, hold then arm then run
   typedef enum logic [1:0]
   {
      RST_HOLD = 2'd0,
      RST_ARM  = 2'd1,
      RST_RUN  = 2'd2
   } rst_state_e;

   typedef logic [1:0] stat_chan_t;

   // ------------------------------
   // bus payloads
   // ------------------------------
   // host or lane request, 42 bits
   typedef struct packed
   {
      stat_op_e                 op;
      logic [`STAT_ADDR_W-1:0]  addr;
      logic [`STAT_DATA_W-1:0]  wdata;
   } stat_req_t;

   // status port reply, ack is a one-cycle pulse
   typedef struct packed
   {
      logic                     ack;
      logic [`STAT_INT_W-1:0]   irq;
      logic [`STAT_DATA_W-1:0]  rdata;
   } stat_rsp_t;

   // merged reply with its channel tag, 43 bits
   typedef struct packed
   {
      stat_rsp_t                rsp;
      stat_chan_t               chan;
   } host_rsp_t;

endpackage

`default_nettype wire

//--- hdl/stat_lane.sv
`include "ddr_stat_consts.svh"
`timescale 1ns/1ns
`default_nettype none

module stat_lane
#(
   parameter int PRESENT = 1
)
(
   input  wire                      clk_main_a0,
   input  wire                      pipe_rst_n,
   input  wire ddr_stat_pkg::stat_req_t  lane_req,
   output ddr_stat_pkg::stat_req_t  ddr_req,
   input  wire ddr_stat_pkg::stat_rsp_t  ddr_rsp,
   output ddr_stat_pkg::stat_rsp_t  lane_rsp
);

   import ddr_stat_pkg::*;

   if (PRESENT != 0)
   begin : g_present
      localparam int STAGES = `STAT_PIPE_STAGES;

      // request side, op is the strobe
      stat_op_e                 req_op_q    [STAGES];
      logic [`STAT_ADDR_W-1:0]  req_addr_q  [STAGES];
      logic [`STAT_DATA_W-1:0]  req_wdata_q [STAGES];
      // reply side, ack is the strobe
      logic [STAGES-1:0]        rsp_ack_q;
      logic [`STAT_INT_W-1:0]   rsp_irq_q   [STAGES];
      logic [`STAT_DATA_W-1:0]  rsp_rdata_q [STAGES];
      // status port owes us a reply
      logic                     in_flight;

      // ------------------------------
      // strobe pipelines
      // ------------------------------
      always_ff @(posedge clk_main_a0)
      begin
         if (!pipe_rst_n)
         begin
            for (int s = 0; s < STAGES; s++)
               req_op_q[s] <= STAT_NOP;
            rsp_ack_q <= '0;
         end
         else
         begin
            req_op_q[0] <= lane_req.op;
            for (int s = 1; s < STAGES; s++)
               req_op_q[s] <= req_op_q[s-1];
            rsp_ack_q <= {rsp_ack_q[STAGES-2:0], ddr_rsp.ack};
         end
      end

      // payload shifts alongside, no reset
      always_ff @(posedge clk_main_a0)
      begin
         req_addr_q[0]  <= lane_req.addr;
         req_wdata_q[0] <= lane_req.wdata;
         rsp_irq_q[0]   <= ddr_rsp.irq;
         rsp_rdata_q[0] <= ddr_rsp.rdata;
         for (int s = 1; s < STAGES; s++)
         begin
            req_addr_q[s]  <= req_addr_q[s-1];
            req_wdata_q[s] <= req_wdata_q[s-1];
            rsp_irq_q[s]   <= rsp_irq_q[s-1];
            rsp_rdata_q[s] <= rsp_rdata_q[s-1];
         end
      end

      assign ddr_req = '{op:    req_op_q[STAGES-1],
                         addr:  req_addr_q[STAGES-1],
                         wdata: req_wdata_q[STAGES-1]};

      assign lane_rsp = '{ack:   rsp_ack_q[STAGES-1],
                          irq:   rsp_irq_q[STAGES-1],
                          rdata: rsp_rdata_q[STAGES-1]};

      // ------------------------------
      // in-flight check
      // ------------------------------
      always_ff @(posedge clk_main_a0)
      begin
         if (!pipe_rst_n)
            in_flight <= 1'b0;
         else if (ddr_req.op != STAT_NOP)
            in_flight <= 1'b1;
         else if (ddr_rsp.ack)
            in_flight <= 1'b0;
      end

      // a reply only ever answers a strobe already sent down the pipe
      a_no_stray_ack: assert property (@(posedge clk_main_a0) disable iff (!pipe_rst_n)
         ddr_rsp.ack |-> (in_flight || ddr_req.op != STAT_NOP));
   end
   else
   begin : g_absent
      logic tie_ack_q;

      // status port stays quiet, its reply is never looked at
      assign ddr_req = '{op: STAT_NOP, addr: '0, wdata: '0};

      // answer every request locally one cycle later
      always_ff @(posedge clk_main_a0)
      begin
         if (!pipe_rst_n)
            tie_ack_q <= 1'b0;
         else
            tie_ack_q <= (lane_req.op != STAT_NOP);
      end

      assign lane_rsp = '{ack: tie_ack_q, irq: '0, rdata: '0};
   end

endmodule

`default_nettype wire

//--- hdl/stat_req_router.sv
`include "ddr_stat_consts.svh"
`timescale 1ns/1ns
`default_nettype none

module stat_req_router
(
   input  wire                      clk_main_a0,
   input  wire                      pipe_rst_n,
   input  wire ddr_stat_pkg::stat_req_t  host_req,
   input  wire ddr_stat_pkg::stat_chan_t host_chan,
   input  wire                      done_ack,
   input  wire ddr_stat_pkg::stat_chan_t done_chan,
   output ddr_stat_pkg::stat_req_t  lane_req [`STAT_NUM_CHAN]
);

   import ddr_stat_pkg::*;

   rst_state_e                  rst_state;
   logic                        take;
   // one strobe per lane, payload shared
   stat_op_e                    op_q [`STAT_NUM_CHAN];
   logic [`STAT_ADDR_W-1:0]     addr_q;
   logic [`STAT_DATA_W-1:0]     wdata_q;
   // channel has a request waiting for its host ack
   logic [`STAT_NUM_CHAN-1:0]   busy;

   // ------------------------------
   // reset release
   // ------------------------------
   // two cycles of pipe_rst_n high before requests count
   always_ff @(posedge clk_main_a0)
   begin
      if (!pipe_rst_n)
         rst_state <= RST_HOLD;
      else
      begin
         case (rst_state)
            RST_HOLD: rst_state <= RST_ARM;
            RST_ARM:  rst_state <= RST_RUN;
            default:  rst_state <= RST_RUN;
         endcase
      end
   end

   // any non-nop op is a request, dropped until run
   assign take = (rst_state == RST_RUN) && (host_req.op != STAT_NOP);

   // ------------------------------
   // channel decode
   // ------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!pipe_rst_n)
      begin
         for (int i = 0; i < `STAT_NUM_CHAN; i++)
            op_q[i] <= STAT_NOP;
      end
      else
      begin
         for (int i = 0; i < `STAT_NUM_CHAN; i++)
            op_q[i] <= (take && host_chan == stat_chan_t'(i)) ? host_req.op : STAT_NOP;
      end
   end

   // payload only meaningful alongside a strobe
   always_ff @(posedge clk_main_a0)
   begin
      if (take)
      begin
         addr_q  <= host_req.addr;
         wdata_q <= host_req.wdata;
      end
   end

   always_comb
   begin
      for (int i = 0; i < `STAT_NUM_CHAN; i++)
         lane_req[i] = '{op: op_q[i], addr: addr_q, wdata: wdata_q};
   end

   // ------------------------------
   // outstanding tracking
   // ------------------------------
   // set on issue, cleared by the merged ack for that channel
   always_ff @(posedge clk_main_a0)
   begin
      if (!pipe_rst_n)
         busy <= '0;
      else
      begin
         for (int i = 0; i < `STAT_NUM_CHAN; i++)
         begin
            if (take && host_chan == stat_chan_t'(i))
               busy[i] <= 1'b1;
            else if (done_ack && done_chan == stat_chan_t'(i))
               busy[i] <= 1'b0;
         end
      end
   end

   // host must only name existing channels
   a_chan_range: assert property (@(posedge clk_main_a0) disable iff (!pipe_rst_n)
      take |-> host_chan < `STAT_NUM_CHAN);

   // one request per channel until its reply has come back through the merger
   a_one_outstanding: assert property (@(posedge clk_main_a0) disable iff (!pipe_rst_n)
      take |-> (!busy[host_chan] || (done_ack && done_chan == host_chan)));

endmodule

`default_nettype wire

//--- hdl/stat_resp_merger.sv
`include "ddr_stat_consts.svh"
`timescale 1ns/1ns
`default_nettype none

module stat_resp_merger
(
   input  wire                      clk_main_a0,
   input  wire                      pipe_rst_n,
   input  wire ddr_stat_pkg::stat_rsp_t  lane_rsp [`STAT_NUM_CHAN],
   output ddr_stat_pkg::host_rsp_t  host_rsp
);

   import ddr_stat_pkg::*;

   // one holding slot per channel, enough with one outstanding each
   logic [`STAT_NUM_CHAN-1:0]  slot_full;
   stat_rsp_t                  slot_rsp [`STAT_NUM_CHAN];
   // slot chosen for output this cycle
   logic [`STAT_NUM_CHAN-1:0]  grant;

   // ------------------------------
   // capture
   // ------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!pipe_rst_n)
         slot_full <= '0;
      else
      begin
         for (int i = 0; i < `STAT_NUM_CHAN; i++)
         begin
            // new reply wins over the free of the same slot
            if (lane_rsp[i].ack)
               slot_full[i] <= 1'b1;
            else if (grant[i])
               slot_full[i] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_main_a0)
   begin
      for (int i = 0; i < `STAT_NUM_CHAN; i++)
      begin
         if (lane_rsp[i].ack)
            slot_rsp[i] <= lane_rsp[i];
      end
   end

   // ------------------------------
   // fixed priority drain
   // ------------------------------
   // walk down from the top so the lowest full slot is picked last
   always_comb
   begin
      grant    = '0;
      host_rsp = '0;
      for (int i = `STAT_NUM_CHAN - 1; i >= 0; i--)
      begin
         if (slot_full[i])
         begin
            grant            = '0;
            grant[i]         = 1'b1;
            host_rsp.rsp     = slot_rsp[i];
            host_rsp.rsp.ack = 1'b1;
            host_rsp.chan    = stat_chan_t'(i);
         end
      end
   end

   // a lane replies again only after its previous reply left this slot
   for (genvar g = 0; g < `STAT_NUM_CHAN; g++)
   begin : g_chk
      a_slot_free: assert property (@(posedge clk_main_a0) disable iff (!pipe_rst_n)
         lane_rsp[g].ack |-> (!slot_full[g] || grant[g]));
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+hdl
hdl/ddr_stat_pkg.sv
hdl/stat_req_router.sv
hdl/stat_lane.sv
hdl/stat_resp_merger.sv
hdl/ddr_stat_bridge.sv
test/ddr_stat_responder.sv
test/tb_ddr_stat_bridge.sv

//--- test/ddr_stat_responder.sv
`include "ddr_stat_consts.svh"
`timescale 1ns/1ns
`default_nettype none

module ddr_stat_responder
(
   input  wire                           clk_main_a0,
   input  wire                           pipe_rst_n,
   input  wire ddr_stat_pkg::stat_req_t  ddr_req,
   output ddr_stat_pkg::stat_rsp_t       ddr_rsp
);

   import ddr_stat_pkg::*;

   // status register file with one word per address
   logic [`STAT_DATA_W-1:0]  regs [256];
   // strobe held one cycle before the reply goes out
   stat_req_t                req_q;

   // ------------------------------
   // power-up contents
   // ------------------------------
   initial
   begin
      req_q   = '{op: STAT_NOP, addr: '0, wdata: '0};
      ddr_rsp = '0;
      for (int a = 0; a < 256; a++)
         regs[a] = {4{a[7:0]}} ^ 32'h5a5a_5a5a;
   end

   // ------------------------------
   // two-cycle reply
   // ------------------------------
   always @(posedge clk_main_a0)
   begin
      if (!pipe_rst_n)
      begin
         req_q   <= '{op: STAT_NOP, addr: '0, wdata: '0};
         ddr_rsp <= '0;
      end
      else
      begin
         req_q   <= ddr_req;
         ddr_rsp <= '0;
         if (req_q.op == STAT_WR)
         begin
            regs[req_q.addr] <= req_q.wdata;
            // write ack carries no data
            ddr_rsp <= '{ack: 1'b1, irq: '0, rdata: '0};
         end
         else if (req_q.op == STAT_RD)
            ddr_rsp <= '{ack: 1'b1, irq: req_q.addr, rdata: regs[req_q.addr]};
      end
   end

endmodule

`default_nettype wire

//--- test/stat_input.txt
# name, idle cycles before issue (decimal), op (1 write, 2 read), channel,
# addr, wdata, expected rdata, expected irq; the last six columns in hex
wr0_a5    0 1 0 a5 12345678 00000000 00
rd0_a5    0 2 0 a5 00000000 12345678 a5
wr0_3c    0 1 0 3c deadbeef 00000000 00
rd0_3c    0 2 0 3c 00000000 deadbeef 3c
rd1_10    0 2 1 10 00000000 00000000 00
wr1_11    0 1 1 11 cafef00d 00000000 00
rd2_20    3 2 2 20 00000000 00000000 00
wr2_21    0 1 2 21 0000beef 00000000 00
wr0_ff    0 1 0 ff 0badf00d 00000000 00
ovl_rd0   0 2 0 ff 00000000 0badf00d ff
ovl_rd1   0 2 1 7e 00000000 00000000 00
ovl_wr2   0 1 2 7f 11223344 00000000 00
pri_rd0   0 2 0 3c 00000000 deadbeef 3c
pri_rd1  16 2 1 01 00000000 00000000 00
pri_rd2   0 2 2 02 00000000 00000000 00
wr0_00    0 1 0 00 ffffffff 00000000 00
rd0_00    0 2 0 00 00000000 ffffffff 00

//--- test/tb_ddr_stat_bridge.sv
`include "ddr_stat_consts.svh"
`timescale 1ns/1ns
`default_nettype none

module tb_ddr_stat_bridge;

   import ddr_stat_pkg::*;

   logic        clk_main_a0;
   logic        pipe_rst_n;
   stat_req_t   host_req;
   stat_chan_t  host_chan;
   host_rsp_t   host_rsp;
   stat_req_t   ddr_req [`STAT_NUM_CHAN];
   stat_rsp_t   ddr_rsp [`STAT_NUM_CHAN];
   stat_rsp_t   model_rsp;

   // expectation that travels with the request on the host port
   string        cur_name;
   logic [31:0]  cur_rdata;
   logic [7:0]   cur_irq;

   // vectors from the data file
   string        v_name  [$];
   int           v_gap   [$];
   logic [1:0]   v_op    [$];
   logic [1:0]   v_chan  [$];
   logic [7:0]   v_addr  [$];
   logic [31:0]  v_wdata [$];
   logic [31:0]  v_rdata [$];
   logic [7:0]   v_irq   [$];

   // scoreboard
   int                          edge_n = 0;
   int                          hi_edges;
   int                          full_at   [`STAT_NUM_CHAN];
   logic [`STAT_NUM_CHAN-1:0]   busy;
   string                       exp_name  [`STAT_NUM_CHAN];
   logic [31:0]                 exp_rdata [`STAT_NUM_CHAN];
   logic [7:0]                  exp_irq   [`STAT_NUM_CHAN];
   int                          ddr_due;
   stat_req_t                   ddr_exp;
   string                       ddr_name;
   int                          acked  = 0;
   int                          checks = 0;
   int                          errors = 0;

   ddr_stat_bridge i_ddr_stat_bridge
   (
      .clk_main_a0 (clk_main_a0),
      .pipe_rst_n  (pipe_rst_n),
      .host_req    (host_req),
      .host_chan   (host_chan),
      .host_rsp    (host_rsp),
      .ddr_req     (ddr_req),
      .ddr_rsp     (ddr_rsp)
   );

   // only channel 0 has a status port behind it
   ddr_stat_responder i_ddr_stat_responder
   (
      .clk_main_a0 (clk_main_a0),
      .pipe_rst_n  (pipe_rst_n),
      .ddr_req     (ddr_req[0]),
      .ddr_rsp     (model_rsp)
   );

   assign ddr_rsp[0] = model_rsp;
   for (genvar g = 1; g < `STAT_NUM_CHAN; g++)
   begin : g_tie
      assign ddr_rsp[g] = '0;
   end

   initial
   begin
      clk_main_a0 = 1'b0;
      forever #50 clk_main_a0 = ~clk_main_a0;
   end

   // ------------------------------
   // helpers
   // ------------------------------
   task automatic compare_field(input string name, input string what,
                                input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp)
      else
      begin
         errors++;
         $display("FAIL %s %s expected %h actual %h", name, what, exp, act);
      end
   endtask

   task automatic check_true(input logic ok, input string msg);
      checks++;
      assert (ok === 1'b1)
      else
      begin
         errors++;
         $display("%s", msg);
      end
   endtask

   task automatic issue_req(input string name, input stat_op_e req_op,
                            input stat_chan_t req_chan, input logic [7:0] req_addr,
                            input logic [31:0] req_wdata, input logic [31:0] rdata,
                            input logic [7:0] irq);
      host_req  <= '{op: req_op, addr: req_addr, wdata: req_wdata};
      host_chan <= req_chan;
      cur_name  <= name;
      cur_rdata <= rdata;
      cur_irq   <= irq;
   endtask

   task automatic drive_idle();
      host_req <= '{op: STAT_NOP, addr: '0, wdata: '0};
      cur_name <= "idle";
   endtask

   task automatic load_vectors();
      int           fd;
      int           n;
      string        line;
      string        name;
      int           gap;
      logic [1:0]   op;
      logic [1:0]   chan;
      logic [7:0]   addr;
      logic [31:0]  wdata;
      logic [31:0]  rdata;
      logic [7:0]   irq;
      fd = $fopen("test/stat_input.txt", "r");
      if (fd == 0)
      begin
         errors++;
         $display("could not open the vector file test/stat_input.txt");
         return;
      end
      while (!$feof(fd))
      begin
         line = "";
         void'($fgets(line, fd));
         // comment and blank lines
         if (line.len() < 2 || line[0] == "#")
            continue;
         n = $sscanf(line, "%s %d %h %h %h %h %h %h",
                     name, gap, op, chan, addr, wdata, rdata, irq);
         if (n == 8)
         begin
            v_name.push_back(name);
            v_gap.push_back(gap);
            v_op.push_back(op);
            v_chan.push_back(chan);
            v_addr.push_back(addr);
            v_wdata.push_back(wdata);
            v_rdata.push_back(rdata);
            v_irq.push_back(irq);
         end
      end
      $fclose(fd);
   endtask

   // ------------------------------
   // reply and strobe monitor
   // ------------------------------
   // slot of channel c fills at edge full_at[c] and shows from the next edge on
   always @(posedge clk_main_a0)
   begin : monitor
      int pick;
      int c;
      if (!pipe_rst_n)
      begin
         hi_edges = 0;
         ddr_due  = -1;
         for (int k = 0; k < `STAT_NUM_CHAN; k++)
            full_at[k] = -1;
         busy <= '0;
      end
      else
      begin
         // lowest full slot drains first
         pick = -1;
         for (int k = `STAT_NUM_CHAN - 1; k >= 0; k--)
            if (full_at[k] >= 0 && full_at[k] < edge_n)
               pick = k;
         if (pick >= 0)
         begin
            compare_field(exp_name[pick], "ack", 32'd1, host_rsp.rsp.ack);
            compare_field(exp_name[pick], "chan", pick, host_rsp.chan);
            compare_field(exp_name[pick], "rdata", exp_rdata[pick], host_rsp.rsp.rdata);
            compare_field(exp_name[pick], "irq", exp_irq[pick], host_rsp.rsp.irq);
            full_at[pick] = -1;
            busy[pick]   <= 1'b0;
         end
         else
            check_true(host_rsp.rsp.ack === 1'b0,
                       $sformatf("unexpected ack from channel %0d at cycle %0d",
                                 host_rsp.chan, edge_n));
         // every ack pulse the host sees
         if (host_rsp.rsp.ack === 1'b1)
            acked++;

         // status port strobe exactly pipe depth plus one after the host request
         if (ddr_due == edge_n)
         begin
            compare_field(ddr_name, "ddr op", ddr_exp.op, ddr_req[0].op);
            compare_field(ddr_name, "ddr addr", ddr_exp.addr, ddr_req[0].addr);
            compare_field(ddr_name, "ddr wdata", ddr_exp.wdata, ddr_req[0].wdata);
            ddr_due = -1;
         end
         else
            check_true(ddr_req[0].op === STAT_NOP,
                       $sformatf("strobe on channel 0 at cycle %0d with none due", edge_n));
         for (int k = 1; k < `STAT_NUM_CHAN; k++)
            check_true(ddr_req[k] === '0,
                       $sformatf("status port of absent channel %0d not idle", k));

         // requests count from the third edge with reset high
         if (hi_edges >= 2 && host_req.op != STAT_NOP)
         begin
            c = host_chan;
            busy[c]     <= 1'b1;
            exp_name[c]  = cur_name;
            exp_rdata[c] = cur_rdata;
            exp_irq[c]   = cur_irq;
            if (((`STAT_PRESENT_MASK >> c) & 1) != 0)
            begin
               ddr_due  = edge_n + `STAT_PIPE_STAGES + 1;
               ddr_exp  = host_req;
               ddr_name = cur_name;
            end
            else
               full_at[c] = edge_n + 2;
         end
         if (model_rsp.ack === 1'b1)
            full_at[0] = edge_n + `STAT_PIPE_STAGES;
         hi_edges++;
      end
      edge_n++;
   end

   // ------------------------------
   // stimulus
   // ------------------------------
   initial
   begin : stimulus
      int    last_chan;
      logic  last_valid;
      logic  sent;
      host_req   = '{op: STAT_NOP, addr: '0, wdata: '0};
      host_chan  = '0;
      pipe_rst_n = 1'b0;
      cur_name   = "idle";
      cur_rdata  = '0;
      cur_irq    = '0;
      load_vectors();
      repeat (5) @(posedge clk_main_a0);
      // first cycle out of reset so the router drops it
      pipe_rst_n <= 1'b1;
      issue_req("rst_release", STAT_RD, 2'd2, 8'h40, '0, '0, '0);
      @(posedge clk_main_a0);
      drive_idle();
      @(posedge clk_main_a0);
      issue_req("rst_release", STAT_RD, 2'd2, 8'h40, '0, '0, '0);
      last_chan  = 2;
      last_valid = 1'b1;

      for (int i = 0; i < v_name.size(); i++)
      begin
         repeat (v_gap[i])
         begin
            @(posedge clk_main_a0);
            drive_idle();
            last_valid = 1'b0;
         end
         // one request per channel until its ack
         sent = 1'b0;
         while (!sent)
         begin
            @(posedge clk_main_a0);
            if (!busy[v_chan[i]] && !(last_valid && last_chan == v_chan[i]))
            begin
               issue_req(v_name[i], stat_op_e'(v_op[i]), v_chan[i], v_addr[i],
                         v_wdata[i], v_rdata[i], v_irq[i]);
               last_chan  = v_chan[i];
               last_valid = 1'b1;
               sent       = 1'b1;
            end
            else
            begin
               drive_idle();
               last_valid = 1'b0;
            end
         end
      end

      // drain and then watch a while for stray acks
      repeat (2)
      begin
         @(posedge clk_main_a0);
         drive_idle();
      end
      while (busy !== '0)
         @(posedge clk_main_a0);
      repeat (10) @(posedge clk_main_a0);

      // one ack per vector plus the late reset-release request
      compare_field("summary", "acks", v_name.size() + 1, acked);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   // ------------------------------
   // watchdog
   // ------------------------------
   initial
   begin : watchdog
      #1;
      repeat ((v_name.size() + 1) * 40 + 200) @(posedge clk_main_a0);
      errors++;
      $display("watchdog expired before all replies came back");
      $display("checks %0d, errors %0d", checks, errors);
      $display("Simulation failed");
      $finish;
   end

endmodule

`default_nettype wire
